// ==== alu.sv ====
// combinational ALU; no overflow detection, addu and subu wrap
// lui takes the immediate from the low half of src_b

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module alu (
    input  logic [`CPU_WORD_W-1:0] src_a,
    input  logic [`CPU_WORD_W-1:0] src_b,
    input  cpu_isa_pkg::alu_op_t   op,
    input  logic [4:0]             shamt,
    output logic [`CPU_WORD_W-1:0] result
);

    always_comb begin
        case (op)
            cpu_isa_pkg::ALU_ADD: result = src_a + src_b;
            cpu_isa_pkg::ALU_SUB: result = src_a - src_b;
            cpu_isa_pkg::ALU_AND: result = src_a & src_b;
            cpu_isa_pkg::ALU_OR:  result = src_a | src_b;
            cpu_isa_pkg::ALU_SLT: begin
                // signed compare
                result = {{(`CPU_WORD_W-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            end
            cpu_isa_pkg::ALU_SLL: result = src_b << shamt;
            cpu_isa_pkg::ALU_LUI: result = {src_b[15:0], 16'h0000};
            default:              result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu_isa_pkg.sv ====
// MIPS subset encodings: addu subu and or slt sll addiu lui lw sw beq bne
// other opcode or function values are legal bit patterns but decode as nop

`default_nettype none

package cpu_isa_pkg;

    // major opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // R-type function code, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    // I-type immediate overlays rd, sa and funct
    typedef struct packed {
        opcode_t    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        funct_t     funct;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_t;

endpackage

`default_nettype wire

// ==== cpu_params.svh ====
// core-wide sizes and the reset vector
// the PC counts words, so CPU_RESET_PC is a word address
// the ISA decode assumes a 32-bit word and 5-bit register numbers

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define CPU_WORD_W 32

// register file size
`define CPU_REG_N 32
`define CPU_REG_W 5

// first fetch address after reset
`define CPU_RESET_PC 32'd0

`endif

// ==== cpu_pipe_pkg.sv ====
// pipeline register payloads, one struct per stage boundary
// an all-zero ctrl field is a bubble in every stage

`default_nettype none

`include "cpu_params.svh"

package cpu_pipe_pkg;

    typedef struct packed {
        logic                 reg_write;
        logic                 reg_dst;    // rd instead of rt
        logic                 alu_src;    // immediate operand
        cpu_isa_pkg::alu_op_t alu_op;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 branch;     // beq or bne
    } ctrl_t;

    // what is still needed once execute is done
    typedef struct packed {
        logic reg_write;
        logic mem_write;
        logic mem_to_reg;
    } em_ctrl_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // fetch -> decode
    typedef struct packed {
        logic [`CPU_WORD_W-1:0] pc;
        logic [`CPU_WORD_W-1:0] pc_next;
        cpu_isa_pkg::instr_t    instr;
    } fd_t;

    // decode -> execute
    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`CPU_WORD_W-1:0] rd_a;
        logic [`CPU_WORD_W-1:0] rd_b;
        logic [`CPU_WORD_W-1:0] imm;
        logic [`CPU_REG_W-1:0]  rs;
        logic [`CPU_REG_W-1:0]  rt;
        logic [`CPU_REG_W-1:0]  rd;
        logic [4:0]             sa;
    } de_t;

    // execute -> memory
    typedef struct packed {
        em_ctrl_t               ctrl;
        logic [`CPU_WORD_W-1:0] alu_result;
        logic [`CPU_WORD_W-1:0] wdata;      // store data
        logic [`CPU_REG_W-1:0]  write_reg;
    } em_t;

    // memory -> writeback
    typedef struct packed {
        logic                   reg_write;
        logic                   mem_to_reg;
        logic [`CPU_WORD_W-1:0] alu_result;
        logic [`CPU_WORD_W-1:0] rdata;
        logic [`CPU_REG_W-1:0]  write_reg;
    } mw_t;

endpackage

`default_nettype wire

// ==== decode_control.sv ====
// main decoder, purely combinational
// unknown opcodes and function codes give an all-zero control word

`timescale 1ns/1ps
`default_nettype none

module decode_control (
    input  cpu_isa_pkg::instr_t instr,
    input  logic                rs_equal,  // forwarded operands compare equal
    output cpu_pipe_pkg::ctrl_t ctrl,
    output logic                pc_src     // take the branch
);

    always_comb begin
        ctrl   = '0;
        pc_src = 1'b0;

        case (instr.op)
            cpu_isa_pkg::OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (instr.funct)
                    cpu_isa_pkg::FN_ADDU: ctrl.alu_op = cpu_isa_pkg::ALU_ADD;
                    cpu_isa_pkg::FN_SUBU: ctrl.alu_op = cpu_isa_pkg::ALU_SUB;
                    cpu_isa_pkg::FN_AND:  ctrl.alu_op = cpu_isa_pkg::ALU_AND;
                    cpu_isa_pkg::FN_OR:   ctrl.alu_op = cpu_isa_pkg::ALU_OR;
                    cpu_isa_pkg::FN_SLT:  ctrl.alu_op = cpu_isa_pkg::ALU_SLT;
                    cpu_isa_pkg::FN_SLL:  ctrl.alu_op = cpu_isa_pkg::ALU_SLL;
                    default: begin
                        ctrl = '0;  // unsupported funct, nop
                    end
                endcase
            end
            cpu_isa_pkg::OP_ADDIU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = cpu_isa_pkg::ALU_ADD;
            end
            cpu_isa_pkg::OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = cpu_isa_pkg::ALU_LUI;
            end
            cpu_isa_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;  // base + offset
                ctrl.alu_op     = cpu_isa_pkg::ALU_ADD;
                ctrl.mem_to_reg = 1'b1;
            end
            cpu_isa_pkg::OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = cpu_isa_pkg::ALU_ADD;
                ctrl.mem_write = 1'b1;
            end
            cpu_isa_pkg::OP_BEQ: begin
                ctrl.branch = 1'b1;
                pc_src      = rs_equal;
            end
            cpu_isa_pkg::OP_BNE: begin
                ctrl.branch = 1'b1;
                pc_src      = ~rs_equal;
            end
            default: ;  // nop
        endcase
    end

endmodule

`default_nettype wire

// ==== hazard_if.sv ====
// register numbers and write flags seen by the hazard unit
// plus its stall and forward decisions

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

interface hazard_if;

    // decode stage
    logic [`CPU_REG_W-1:0] rs_d;
    logic [`CPU_REG_W-1:0] rt_d;
    logic                  branch_d;

    // execute stage
    logic [`CPU_REG_W-1:0] rs_e;
    logic [`CPU_REG_W-1:0] rt_e;
    logic [`CPU_REG_W-1:0] write_reg_e;
    logic                  reg_write_e;
    logic                  mem_to_reg_e;

    // memory and writeback stages
    logic [`CPU_REG_W-1:0] write_reg_m;
    logic                  reg_write_m;
    logic                  mem_to_reg_m;
    logic [`CPU_REG_W-1:0] write_reg_w;
    logic                  reg_write_w;

    // decisions
    logic                  stall;
    cpu_pipe_pkg::fwd_sel_t fwd_a_e;
    cpu_pipe_pkg::fwd_sel_t fwd_b_e;
    logic                  fwd_a_d;
    logic                  fwd_b_d;

    modport pipe (
        output rs_d, rt_d, branch_d,
        output rs_e, rt_e, write_reg_e, reg_write_e, mem_to_reg_e,
        output write_reg_m, reg_write_m, mem_to_reg_m, write_reg_w, reg_write_w,
        input  stall, fwd_a_e, fwd_b_e, fwd_a_d, fwd_b_d
    );

    modport hazard (
        input  rs_d, rt_d, branch_d,
        input  rs_e, rt_e, write_reg_e, reg_write_e, mem_to_reg_e,
        input  write_reg_m, reg_write_m, mem_to_reg_m, write_reg_w, reg_write_w,
        output stall, fwd_a_e, fwd_b_e, fwd_a_d, fwd_b_d
    );

endinterface

`default_nettype wire

// ==== hazard_unit.sv ====
// forwarding and stall decisions, purely combinational
// forwarding into decode only comes from memory; writeback goes via the RF bypass

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module hazard_unit (
    hazard_if.hazard hz
);

    logic load_use;      // load in E feeds the instruction in D
    logic branch_wait;   // branch operand not ready yet

    // register 0 never counts as a dependency
    function automatic logic hit(input logic [`CPU_REG_W-1:0] src,
                                 input logic [`CPU_REG_W-1:0] dst);
        return (src != '0) && (src == dst);
    endfunction

    // newest value first: memory beats writeback
    function automatic cpu_pipe_pkg::fwd_sel_t fwd_e(input logic [`CPU_REG_W-1:0] src);
        if (hz.reg_write_m && hit(src, hz.write_reg_m))
            return cpu_pipe_pkg::FWD_MEM;
        if (hz.reg_write_w && hit(src, hz.write_reg_w))
            return cpu_pipe_pkg::FWD_WB;
        return cpu_pipe_pkg::FWD_NONE;
    endfunction

    // ****************************************
    // forwarding
    // ****************************************

    always_comb begin
        hz.fwd_a_e = fwd_e(hz.rs_e);
        hz.fwd_b_e = fwd_e(hz.rt_e);
        hz.fwd_a_d = hz.reg_write_m && hit(hz.rs_d, hz.write_reg_m);
        hz.fwd_b_d = hz.reg_write_m && hit(hz.rt_d, hz.write_reg_m);
    end

    // ****************************************
    // stalls
    // ****************************************

    always_comb begin
        load_use = hz.mem_to_reg_e
                && (hit(hz.rs_d, hz.write_reg_e) || hit(hz.rt_d, hz.write_reg_e));

        branch_wait = hz.branch_d && (
               (hz.reg_write_e
                && (hit(hz.rs_d, hz.write_reg_e) || hit(hz.rt_d, hz.write_reg_e)))
            || (hz.mem_to_reg_m
                && (hit(hz.rs_d, hz.write_reg_m) || hit(hz.rt_d, hz.write_reg_m))));

        hz.stall = load_use || branch_wait;
    end

endmodule

`default_nettype wire

// ==== pcpu_chk.sv ====
// protocol assertions for pcpu_top, attached by bind
// stall and the register write port are taken from inside the core

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module pcpu_chk (
    input logic                   clk,
    input logic                   reset,
    input logic [`CPU_WORD_W-1:0] im_addr,
    input logic                   dm_we,
    input logic                   stall,
    input logic                   rf_we,
    input logic [`CPU_REG_W-1:0]  rf_waddr
);

    a_no_store_after_reset: assert property (@(posedge clk) reset |=> !dm_we)
        else $error("dm_we high in the cycle after reset");

    a_reset_pc: assert property (@(posedge clk) reset |=> (im_addr == `CPU_RESET_PC))
        else $error("fetch address not at the reset PC after reset");

    // a stalled PC must not move
    a_stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
                                       stall |=> $stable(im_addr))
        else $error("fetch address moved during a stall");

    a_no_r0_write: assert property (@(posedge clk) !(rf_we && rf_waddr == '0))
        else $error("register file written at address 0");

endmodule

bind pcpu_top pcpu_chk i_chk (
    .clk      (clk),
    .reset    (reset),
    .im_addr  (im_addr),
    .dm_we    (dm_we),
    .stall    (hz.stall),
    .rf_we    (mw.reg_write),
    .rf_waddr (mw.write_reg)
);

`default_nettype wire

// ==== pcpu_top.sv ====
// five-stage pipelined core, word-addressed PC, no branch delay slot
// both memories must answer in the same cycle; debug address 0 reads the fetch PC

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module pcpu_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CPU_REG_W-1:0]  reg_addr,   // debug register number
    output logic [`CPU_WORD_W-1:0] reg_data,
    output logic [`CPU_WORD_W-1:0] im_addr,
    input  logic [`CPU_WORD_W-1:0] im_data,
    output logic [`CPU_WORD_W-1:0] dm_addr,
    output logic                   dm_we,
    output logic [`CPU_WORD_W-1:0] dm_wdata,
    input  logic [`CPU_WORD_W-1:0] dm_rdata
);

    hazard_if hz ();

    logic [`CPU_WORD_W-1:0] pc;
    logic [`CPU_WORD_W-1:0] pc_next;
    logic [`CPU_WORD_W-1:0] branch_target;
    logic                   pc_src;
    logic                   taken;          // resolved and not held by a stall

    cpu_pipe_pkg::fd_t   fd;
    cpu_pipe_pkg::de_t   de;
    cpu_pipe_pkg::em_t   em;
    cpu_pipe_pkg::mw_t   mw;
    cpu_pipe_pkg::ctrl_t ctrl_d;

    logic [`CPU_WORD_W-1:0] rf_a_d, rf_b_d, dbg_data;
    logic [`CPU_WORD_W-1:0] cmp_a_d, cmp_b_d, imm_d;
    logic [`CPU_WORD_W-1:0] src_a_e, src_b_e, store_e, alu_result_e;
    logic [`CPU_REG_W-1:0]  write_reg_e;
    logic [`CPU_WORD_W-1:0] wb_data;

    // ****************************************
    // fetch
    // ****************************************

    assign pc_next = pc + 1'b1;
    assign im_addr = pc;
    assign taken   = pc_src & ~hz.stall;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `CPU_RESET_PC;
        else if (!hz.stall)
            pc <= taken ? branch_target : pc_next;
    end

    always_ff @(posedge clk) begin
        if (reset || taken) begin
            fd <= '0;  // squash the wrong-path fetch
        end else if (!hz.stall) begin
            fd.pc      <= pc;
            fd.pc_next <= pc_next;
            fd.instr   <= im_data;
        end
    end

    // ****************************************
    // decode
    // ****************************************

    assign reg_data = (reg_addr != '0) ? dbg_data : pc;

    register_file u_rf (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (fd.instr.rs),
        .rd_addr_b (fd.instr.rt),
        .dbg_addr  (reg_addr),
        .wr_addr   (mw.write_reg),
        .wr_data   (wb_data),
        .wr_en     (mw.reg_write),
        .rd_data_a (rf_a_d),
        .rd_data_b (rf_b_d),
        .dbg_data  (dbg_data)
    );

    assign imm_d = {{16{fd.instr.rd[4]}}, fd.instr.rd, fd.instr.sa, fd.instr.funct};
    assign branch_target = fd.pc_next + imm_d;

    // early compare needs the value sitting in memory
    assign cmp_a_d = hz.fwd_a_d ? em.alu_result : rf_a_d;
    assign cmp_b_d = hz.fwd_b_d ? em.alu_result : rf_b_d;

    decode_control u_ctrl (
        .instr    (fd.instr),
        .rs_equal (cmp_a_d == cmp_b_d),
        .ctrl     (ctrl_d),
        .pc_src   (pc_src)
    );

    always_ff @(posedge clk) begin
        if (reset || hz.stall) begin
            de <= '0;  // bubble
        end else begin
            de.ctrl <= ctrl_d;
            de.rd_a <= rf_a_d;
            de.rd_b <= rf_b_d;
            de.imm  <= imm_d;
            de.rs   <= fd.instr.rs;
            de.rt   <= fd.instr.rt;
            de.rd   <= fd.instr.rd;
            de.sa   <= fd.instr.sa;
        end
    end

    // ****************************************
    // execute
    // ****************************************

    always_comb begin
        case (hz.fwd_a_e)
            cpu_pipe_pkg::FWD_MEM: src_a_e = em.alu_result;
            cpu_pipe_pkg::FWD_WB:  src_a_e = wb_data;
            default:               src_a_e = de.rd_a;
        endcase
        case (hz.fwd_b_e)
            cpu_pipe_pkg::FWD_MEM: store_e = em.alu_result;
            cpu_pipe_pkg::FWD_WB:  store_e = wb_data;
            default:               store_e = de.rd_b;
        endcase
    end

    assign src_b_e     = de.ctrl.alu_src ? de.imm : store_e;
    assign write_reg_e = de.ctrl.reg_dst ? de.rd : de.rt;

    alu u_alu (
        .src_a  (src_a_e),
        .src_b  (src_b_e),
        .op     (de.ctrl.alu_op),
        .shamt  (de.sa),
        .result (alu_result_e)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            em <= '0;
        end else begin
            // writes to $0 are dropped here
            em.ctrl.reg_write  <= de.ctrl.reg_write && (write_reg_e != '0);
            em.ctrl.mem_write  <= de.ctrl.mem_write;
            em.ctrl.mem_to_reg <= de.ctrl.mem_to_reg;
            em.alu_result      <= alu_result_e;
            em.wdata           <= store_e;
            em.write_reg       <= write_reg_e;
        end
    end

    // ****************************************
    // memory
    // ****************************************

    assign dm_addr  = em.alu_result;
    assign dm_we    = em.ctrl.mem_write;
    assign dm_wdata = em.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            mw <= '0;
        end else begin
            mw.reg_write  <= em.ctrl.reg_write;
            mw.mem_to_reg <= em.ctrl.mem_to_reg;
            mw.alu_result <= em.alu_result;
            mw.rdata      <= dm_rdata;
            mw.write_reg  <= em.write_reg;
        end
    end

    // ****************************************
    // writeback and hazard unit
    // ****************************************

    assign wb_data = mw.mem_to_reg ? mw.rdata : mw.alu_result;

    assign hz.rs_d         = fd.instr.rs;
    assign hz.rt_d         = fd.instr.rt;
    assign hz.branch_d     = ctrl_d.branch;
    assign hz.rs_e         = de.rs;
    assign hz.rt_e         = de.rt;
    assign hz.write_reg_e  = write_reg_e;
    assign hz.reg_write_e  = de.ctrl.reg_write;
    assign hz.mem_to_reg_e = de.ctrl.mem_to_reg;
    assign hz.write_reg_m  = em.write_reg;
    assign hz.reg_write_m  = em.ctrl.reg_write;
    assign hz.mem_to_reg_m = em.ctrl.mem_to_reg;
    assign hz.write_reg_w  = mw.write_reg;
    assign hz.reg_write_w  = mw.reg_write;

    hazard_unit u_hazard (
        .hz (hz.hazard)
    );

endmodule

`default_nettype wire

// ==== register_file.sv ====
// 32 x 32 register file, written on the rising edge
// reads are combinational and see a same-cycle write; register 0 reads zero

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CPU_REG_W-1:0]  rd_addr_a,
    input  logic [`CPU_REG_W-1:0]  rd_addr_b,
    input  logic [`CPU_REG_W-1:0]  dbg_addr,
    input  logic [`CPU_REG_W-1:0]  wr_addr,
    input  logic [`CPU_WORD_W-1:0] wr_data,
    input  logic                   wr_en,
    output logic [`CPU_WORD_W-1:0] rd_data_a,
    output logic [`CPU_WORD_W-1:0] rd_data_b,
    output logic [`CPU_WORD_W-1:0] dbg_data
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_REG_N];

    // write-first bypass
    function automatic logic [`CPU_WORD_W-1:0] read_port(input logic [`CPU_REG_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wr_en && addr == wr_addr)
            return wr_data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_N; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
        dbg_data  = read_port(dbg_addr);
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module tb_pcpu -f src.f -o sim_pcpu \
    && ./obj_dir/sim_pcpu | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== src.f ====
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
hazard_if.sv
decode_control.sv
register_file.sv
alu.sv
hazard_unit.sv
pcpu_top.sv
pcpu_chk.sv
tb_pcpu.sv

// ==== tb_pcpu.sv ====
// testbench for pcpu_top; both memories are 64-word arrays, so addresses alias above word 63
// every program ends in a self-loop, so the final state does not depend on pipeline timing

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_pcpu;

    localparam int CLK_PERIOD    = 20;
    localparam int MEM_WORDS     = 64;
    localparam int BUDGET_ARITH  = 30;
    localparam int BUDGET_LOAD   = 40;
    localparam int BUDGET_BRANCH = 40;
    localparam int BUDGET_ZERO   = 30;
    localparam int BUDGET_RESET  = 50;   // partial run included
    localparam int OVERHEAD      = 40;   // reset plus debug reads
    localparam int WATCHDOG_CYCLES = 2 * (BUDGET_ARITH + BUDGET_LOAD + BUDGET_BRANCH
                                          + BUDGET_ZERO + BUDGET_RESET + 5 * OVERHEAD);

    logic                   clk = 1'b0;
    logic                   reset;
    logic [`CPU_REG_W-1:0]  reg_addr;
    logic [`CPU_WORD_W-1:0] reg_data;
    logic [`CPU_WORD_W-1:0] im_addr, im_data;
    logic [`CPU_WORD_W-1:0] dm_addr, dm_wdata, dm_rdata;
    logic                   dm_we;
    logic                   dm_clear;
    logic                   reset_seen = 1'b0;
    int                     stores_in_reset = 0;

    logic [`CPU_WORD_W-1:0] imem [MEM_WORDS] = '{default: '0};
    logic [`CPU_WORD_W-1:0] dmem [MEM_WORDS] = '{default: '0};
    cpu_isa_pkg::instr_t    prog [$];

    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pcpu_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    // ****************************************
    // memory models
    // ****************************************

    assign im_data  = imem[im_addr[5:0]];
    assign dm_rdata = dmem[dm_addr[5:0]];

    always @(posedge clk) begin
        if (dm_clear) begin
            for (int i = 0; i < MEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (dm_we) begin
            dmem[dm_addr[5:0]] <= dm_wdata;
        end
    end

    // stores after the first reset edge should never happen
    always @(posedge clk) begin
        if (reset && reset_seen && dm_we)
            stores_in_reset <= stores_in_reset + 1;
        reset_seen <= reset;
    end

    // ****************************************
    // encoding and program helpers
    // ****************************************

    function automatic cpu_isa_pkg::instr_t r_type(input cpu_isa_pkg::funct_t fn,
                                                   input logic [4:0] rd, rs, rt,
                                                   input logic [4:0] sa = 5'd0);
        cpu_isa_pkg::instr_t i;
        i.op    = cpu_isa_pkg::OP_RTYPE;
        i.rs    = rs;
        i.rt    = rt;
        i.rd    = rd;
        i.sa    = sa;
        i.funct = fn;
        return i;
    endfunction

    function automatic cpu_isa_pkg::instr_t i_type(input cpu_isa_pkg::opcode_t op,
                                                   input logic [4:0] rs, rt,
                                                   input logic [15:0] imm);
        return cpu_isa_pkg::instr_t'({op, rs, rt, imm});
    endfunction

    function automatic logic [`CPU_WORD_W-1:0] sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // beq $0,$0,-1 at the end, returns its word address
    function automatic logic [`CPU_WORD_W-1:0] close_program();
        prog.push_back(i_type(cpu_isa_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff));
        return prog.size() - 1;
    endfunction

    task automatic reset_and_load();
        @(posedge clk);
        #2;
        reset    = 1'b1;
        dm_clear = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = '0;
        for (int i = 0; i < prog.size(); i++)
            imem[i] = prog[i];
        @(posedge clk);
        #2;
        dm_clear = 1'b0;
        repeat (9) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic run_program(input int cycles);
        reset_and_load();
        repeat (cycles) @(posedge clk);
    endtask

    task automatic read_reg(input logic [`CPU_REG_W-1:0] n,
                            output logic [`CPU_WORD_W-1:0] v);
        @(posedge clk);
        #2;
        reg_addr = n;
        #1;
        v = reg_data;
    endtask

    // ****************************************
    // compare tasks
    // ****************************************

    task automatic check_word(input string name, input logic [`CPU_WORD_W-1:0] got,
                              input logic [`CPU_WORD_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(input logic [`CPU_WORD_W-1:0] loop_pc);
        logic [`CPU_WORD_W-1:0] first, second;
        logic                   ok;
        read_reg(5'd0, first);
        read_reg(5'd0, second);
        checks++;
        // fetch alternates between the loop and its squashed successor
        ok = (first == loop_pc && second == loop_pc + 32'd1)
          || (first == loop_pc + 32'd1 && second == loop_pc);
        if (!ok) begin
            errors++;
            test_errors++;
            $display("error reg_data: got %h then %h expected %h and %h in turn",
                     first, second, loop_pc, loop_pc + 32'd1);
        end
    endtask

    task automatic expect_reg(input logic [`CPU_REG_W-1:0] n,
                              input logic [`CPU_WORD_W-1:0] exp);
        logic [`CPU_WORD_W-1:0] got;
        read_reg(n, got);
        check_word($sformatf("reg_data[r%0d]", n), got, exp);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // ****************************************
    // directed tests
    // ****************************************

    task automatic arith_chain();
        logic [31:0]            rnd;
        logic [15:0]            a, b;
        logic [4:0]             sa;
        logic [`CPU_WORD_W-1:0] r [9];
        rnd = $urandom();
        a   = rnd[15:0];
        b   = rnd[31:16];
        rnd = $urandom();
        sa  = rnd[4:0];
        prog.delete();
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd1, a));
        prog.push_back(i_type(cpu_isa_pkg::OP_LUI, 5'd0, 5'd2, b));
        prog.push_back(r_type(cpu_isa_pkg::FN_ADDU, 5'd3, 5'd1, 5'd2));
        prog.push_back(r_type(cpu_isa_pkg::FN_SUBU, 5'd4, 5'd1, 5'd3));
        prog.push_back(r_type(cpu_isa_pkg::FN_AND, 5'd5, 5'd4, 5'd3));
        prog.push_back(r_type(cpu_isa_pkg::FN_OR, 5'd6, 5'd5, 5'd2));
        prog.push_back(r_type(cpu_isa_pkg::FN_SLT, 5'd7, 5'd4, 5'd1));
        prog.push_back(r_type(cpu_isa_pkg::FN_SLL, 5'd8, 5'd0, 5'd6, sa));
        void'(close_program());
        r[1] = sext(a);
        r[2] = {b, 16'h0000};
        r[3] = r[1] + r[2];
        r[4] = r[1] - r[3];
        r[5] = r[4] & r[3];
        r[6] = r[5] | r[2];
        r[7] = ($signed(r[4]) < $signed(r[1])) ? 32'd1 : 32'd0;
        r[8] = r[6] << sa;
        run_program(BUDGET_ARITH);
        for (int n = 1; n <= 8; n++)
            expect_reg(n[4:0], r[n]);
        finish_test("arith_chain");
    endtask

    task automatic load_use();
        logic [31:0]            rnd;
        logic [`CPU_WORD_W-1:0] m4, m5;
        rnd = $urandom();
        m4  = sext(rnd[15:0]);
        m5  = sext(rnd[31:16]);
        prog.delete();
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd1, rnd[15:0]));
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd2, rnd[31:16]));
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'd4));   // base
        prog.push_back(i_type(cpu_isa_pkg::OP_SW, 5'd9, 5'd1, 16'd0));
        prog.push_back(i_type(cpu_isa_pkg::OP_SW, 5'd9, 5'd2, 16'd1));
        prog.push_back(i_type(cpu_isa_pkg::OP_LW, 5'd9, 5'd3, 16'd0));
        prog.push_back(r_type(cpu_isa_pkg::FN_ADDU, 5'd4, 5'd3, 5'd2));     // needs the stall
        prog.push_back(i_type(cpu_isa_pkg::OP_LW, 5'd9, 5'd5, 16'd1));
        prog.push_back(r_type(cpu_isa_pkg::FN_ADDU, 5'd6, 5'd5, 5'd5));
        prog.push_back(i_type(cpu_isa_pkg::OP_SW, 5'd9, 5'd6, 16'd2));
        void'(close_program());
        run_program(BUDGET_LOAD);
        expect_reg(5'd4, m4 + m5);
        expect_reg(5'd6, m5 + m5);
        check_word("dmem[4]", dmem[4], m4);
        check_word("dmem[5]", dmem[5], m5);
        check_word("dmem[6]", dmem[6], m5 + m5);
        finish_test("load_use");
    endtask

    task automatic branch_cases();
        logic [31:0]            rnd;
        logic [15:0]            x;
        logic [`CPU_WORD_W-1:0] loop_pc;
        rnd = $urandom();
        x   = rnd[15:0];
        prog.delete();
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd1, x));
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd2, x));
        prog.push_back(i_type(cpu_isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1));     // taken
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd10, 16'd1));
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd3, x ^ 16'h0001));
        prog.push_back(i_type(cpu_isa_pkg::OP_BNE, 5'd3, 5'd1, 16'd1));     // taken
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd11, 16'd1));
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd4, x ^ 16'h0002));
        prog.push_back(i_type(cpu_isa_pkg::OP_BEQ, 5'd4, 5'd1, 16'd1));     // not taken
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd12, 16'd1));
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd5, x));
        prog.push_back(i_type(cpu_isa_pkg::OP_BNE, 5'd5, 5'd1, 16'd1));     // not taken
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd13, 16'd1));
        loop_pc = close_program();
        run_program(BUDGET_BRANCH);
        expect_reg(5'd10, 32'd0);
        expect_reg(5'd11, 32'd0);
        expect_reg(5'd12, 32'd1);
        expect_reg(5'd13, 32'd1);
        check_pc(loop_pc);
        finish_test("branch_cases");
    endtask

    task automatic zero_register();
        logic [31:0]            rnd;
        logic [`CPU_WORD_W-1:0] loop_pc;
        rnd = $urandom();
        prog.delete();
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h1234));
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd1, rnd[15:0]));
        prog.push_back(r_type(cpu_isa_pkg::FN_ADDU, 5'd0, 5'd1, 5'd1));
        prog.push_back(r_type(cpu_isa_pkg::FN_ADDU, 5'd2, 5'd0, 5'd1));
        loop_pc = close_program();
        run_program(BUDGET_ZERO);
        expect_reg(5'd2, sext(rnd[15:0]));  // $0 stayed zero
        check_pc(loop_pc);
        finish_test("zero_register");
    endtask

    task automatic reset_restart();
        logic [31:0]            rnd;
        logic [`CPU_WORD_W-1:0] v;
        rnd = $urandom();
        v   = sext(rnd[15:0]);
        prog.delete();
        prog.push_back(i_type(cpu_isa_pkg::OP_ADDIU, 5'd0, 5'd1, rnd[15:0]));
        prog.push_back(i_type(cpu_isa_pkg::OP_SW, 5'd0, 5'd1, 16'd8));
        prog.push_back(i_type(cpu_isa_pkg::OP_LW, 5'd0, 5'd2, 16'd8));
        prog.push_back(r_type(cpu_isa_pkg::FN_ADDU, 5'd3, 5'd2, 5'd1));
        prog.push_back(i_type(cpu_isa_pkg::OP_SW, 5'd0, 5'd3, 16'd9));
        void'(close_program());
        run_program(4);   // stores still in flight
        #2;
        reg_addr = '0;
        reset_and_load();
        #1;
        check_word("reg_data[pc]", reg_data, `CPU_RESET_PC);
        repeat (BUDGET_RESET) @(posedge clk);
        expect_reg(5'd3, v + v);
        check_word("dmem[8]", dmem[8], v);
        check_word("dmem[9]", dmem[9], v + v);
        checks++;
        if (stores_in_reset != 0) begin
            errors++;
            test_errors++;
            $display("%0d store(s) reached the data memory while reset was held",
                     stores_in_reset);
        end
        finish_test("reset_restart");
    endtask

    // ****************************************
    // main sequence and watchdog
    // ****************************************

    initial begin
        reset    = 1'b1;
        reg_addr = '0;
        dm_clear = 1'b0;
        void'($urandom(32'h6fd6_2a63));
        arith_chain();
        load_use();
        branch_cases();
        zero_register();
        reset_restart();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
